// File: hw/lb_pkg.sv
// Local-bus definitions
// Bus widths, register and memory address map, read latency
`default_nettype none

package lb_pkg;

   // ------------------------------
   // Bus widths
   // ------------------------------
   localparam int LB_AW = 24;
   localparam int LB_DW = 32;

   // One bus address and one bus data word
   typedef logic [LB_AW-1:0] lb_addr_t;
   typedef logic [LB_DW-1:0] lb_data_t;

   // ------------------------------
   // Address map
   // ------------------------------
   // Read-only status register
   localparam lb_addr_t LB_ADDR_STATUS   = 24'd0;
   // Control register, bit 0 arms the trace
   localparam lb_addr_t LB_ADDR_CTRL     = 24'd1;
   // Trace memory window, aligned to its own size
   localparam lb_addr_t LB_ADDR_MEM_BASE = 24'd256;

   // Status word layout
   localparam int LB_STAT_RUN_BIT   = 0;
   localparam int LB_STAT_FULL_BIT  = 1;
   localparam int LB_STAT_COUNT_LSB = 8;

   // Strobe to valid read data, in lb_clk cycles
   localparam int LB_READ_LAT = 2;

endpackage

`default_nettype wire

// File: hw/trace_pkg.sv
// Trace scope definitions
// Sample, run length and record widths, memory depth, store FSM states
`default_nettype none

package trace_pkg;

   // ------------------------------
   // Widths and depth
   // ------------------------------
   localparam int TRACE_DW    = 16;
   // Run length width, longest run is 255
   localparam int TRACE_TW    = 8;
   localparam int TRACE_AW    = 6;
   // 64 records
   localparam int TRACE_DEPTH = 2**TRACE_AW;
   // Record is run length on top of the value
   localparam int TRACE_RW    = TRACE_TW + TRACE_DW;

   typedef logic [TRACE_DW-1:0] trace_data_t;
   typedef logic [TRACE_TW-1:0] trace_run_t;
   typedef logic [TRACE_RW-1:0] trace_rec_t;
   typedef logic [TRACE_AW-1:0] trace_addr_t;
   // One extra bit so a full memory count of 64 fits
   typedef logic [TRACE_AW:0]   trace_count_t;

   // Saturation point of the run counter
   localparam trace_run_t TRACE_RUN_MAX = '1;

   // ------------------------------
   // Store FSM
   // ------------------------------
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,
      ST_FULL
   } store_state_t;

endpackage

`default_nettype wire

// File: hw/trace_run_encoder.sv
// Trace run-length encoder
// Compares each sample with the held one and emits one record
// per run of equal values, or per 255-cycle chunk of a long run
`timescale 1ns/1ns
`default_nettype none

module trace_run_encoder (
   input  logic                   lb_clk,
   input  logic                   i_arst_n,
   input  logic                   i_arm,
   input  trace_pkg::trace_data_t i_sample,
   output logic                   o_rec_valid,
   output trace_pkg::trace_rec_t  o_rec
);
   import trace_pkg::*;

   trace_data_t held;
   trace_run_t  run_cnt;
   logic        active;
   logic        same;
   logic        at_max;
   logic        close_run;

   // ------------------------------
   // Run detection
   // ------------------------------
   assign same   = (i_sample == held);
   assign at_max = (run_cnt == TRACE_RUN_MAX);
   // Value changed or counter saturated
   assign close_run = active && !i_arm && (!same || at_max);

   // Control state
   always_ff @(posedge lb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         active      <= 1'b0;
         run_cnt     <= '0;
         o_rec_valid <= 1'b0;
      end else begin
         // Record strobe lasts one cycle
         o_rec_valid <= close_run;
         if (i_arm) begin
            // Arm cycle sample opens the first run
            active  <= 1'b1;
            run_cnt <= trace_run_t'(1);
         end else if (close_run) begin
            run_cnt <= trace_run_t'(1);
         end else if (active) begin
            run_cnt <= run_cnt + trace_run_t'(1);
         end
      end
   end

   // Held value and outgoing record
   always_ff @(posedge lb_clk) begin
      if (i_arm || close_run) begin
         held <= i_sample;
      end
      if (close_run) begin
         o_rec <= {run_cnt, held};
      end
   end

   // ------------------------------
   // Checks
   // ------------------------------
   // An emitted record always carries at least one sample
   a_rec_len_nonzero : assert property (
      @(posedge lb_clk) disable iff (!i_arst_n)
      o_rec_valid |-> (o_rec[TRACE_RW-1 -: TRACE_TW] != '0)
   );

endmodule

`default_nettype wire

// File: hw/trace_store.sv
// Trace record store
// Arming FSM, write address and record count, plus the
// 64-entry record memory with a registered read port
`timescale 1ns/1ns
`default_nettype none

module trace_store (
   input  logic                    lb_clk,
   input  logic                    i_arst_n,
   input  logic                    i_arm,
   input  logic                    i_rec_valid,
   input  trace_pkg::trace_rec_t   i_rec,
   input  trace_pkg::trace_addr_t  i_rd_addr,
   output trace_pkg::trace_rec_t   o_rd_data,
   output trace_pkg::store_state_t o_state,
   output trace_pkg::trace_count_t o_rec_count
);
   import trace_pkg::*;

   store_state_t state;
   trace_addr_t  wr_addr;
   trace_count_t rec_count;
   trace_rec_t   mem [TRACE_DEPTH];
   logic         wr_en;
   logic         last_wr;

   // Records only land while running, a coincident arm wins
   assign wr_en   = i_rec_valid && (state == ST_RUN) && !i_arm;
   assign last_wr = wr_en && (rec_count == trace_count_t'(TRACE_DEPTH - 1));

   // ------------------------------
   // FSM and write pointer
   // ------------------------------
   always_ff @(posedge lb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state     <= ST_IDLE;
         wr_addr   <= '0;
         rec_count <= '0;
      end else if (i_arm) begin
         // Re-arm from any state restarts at index 0
         state     <= ST_RUN;
         wr_addr   <= '0;
         rec_count <= '0;
      end else begin
         case (state)
            ST_RUN: begin
               if (wr_en) begin
                  wr_addr   <= wr_addr + trace_addr_t'(1);
                  rec_count <= rec_count + trace_count_t'(1);
               end
               // Memory full after the 64th write
               if (last_wr) begin
                  state <= ST_FULL;
               end
            end
            ST_FULL: begin
               // Hold contents until re-armed
               state <= ST_FULL;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // ------------------------------
   // Record memory
   // ------------------------------
   always_ff @(posedge lb_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= i_rec;
      end
      // One cycle read latency
      o_rd_data <= mem[i_rd_addr];
   end

   assign o_state     = state;
   assign o_rec_count = rec_count;

   // ------------------------------
   // Checks
   // ------------------------------
   // Every write finds a free slot, none once the memory is full
   a_no_write_full : assert property (
      @(posedge lb_clk) disable iff (!i_arst_n)
      wr_en |-> (rec_count < trace_count_t'(TRACE_DEPTH))
   );

   // Count never passes the memory depth
   a_count_bound : assert property (
      @(posedge lb_clk) disable iff (!i_arst_n)
      rec_count <= trace_count_t'(TRACE_DEPTH)
   );

endmodule

`default_nettype wire

// File: hw/lb_read_mux.sv
// Local-bus decode and readout
// Decodes bus accesses, issues the trace arm pulse and returns
// the status word or a trace memory record after two cycles
`timescale 1ns/1ns
`default_nettype none

module lb_read_mux (
   input  logic                    lb_clk,
   input  logic                    i_arst_n,
   input  logic                    i_lb_valid,
   input  logic                    i_lb_rnw,
   input  lb_pkg::lb_addr_t        i_lb_addr,
   input  lb_pkg::lb_data_t        i_lb_wdata,
   input  logic                    i_lb_renable,
   input  trace_pkg::store_state_t i_state,
   input  trace_pkg::trace_count_t i_rec_count,
   input  trace_pkg::trace_rec_t   i_mem_data,
   output trace_pkg::trace_addr_t  o_mem_addr,
   output logic                    o_arm,
   output logic                    o_rd_pulse,
   output lb_pkg::lb_data_t        o_lb_rdata
);
   import lb_pkg::*;
   import trace_pkg::*;

   logic     rd_stb;
   logic     wr_stb;
   logic     hit_status;
   logic     hit_ctrl;
   logic     hit_mem;
   logic     rd_q1;
   logic     sel_status_q1;
   logic     sel_mem_q1;
   lb_data_t status_word;
   lb_data_t mem_word;

   // ------------------------------
   // Address decode
   // ------------------------------
   assign rd_stb     = i_lb_valid && i_lb_rnw && i_lb_renable;
   assign wr_stb     = i_lb_valid && !i_lb_rnw;
   assign hit_status = (i_lb_addr == LB_ADDR_STATUS);
   assign hit_ctrl   = (i_lb_addr == LB_ADDR_CTRL);
   // Window is size aligned, so upper bits pick it
   assign hit_mem    = (i_lb_addr[LB_AW-1:TRACE_AW] == LB_ADDR_MEM_BASE[LB_AW-1:TRACE_AW]);

   // Memory sees the address during the strobe cycle
   assign o_mem_addr = i_lb_addr[TRACE_AW-1:0];

   // Stage one registers the region and the control write
   always_ff @(posedge lb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rd_q1         <= 1'b0;
         sel_status_q1 <= 1'b0;
         sel_mem_q1    <= 1'b0;
         o_arm         <= 1'b0;
      end else begin
         rd_q1         <= rd_stb;
         sel_status_q1 <= rd_stb && hit_status;
         sel_mem_q1    <= rd_stb && hit_mem;
         // Arm fires the cycle after the write strobe
         o_arm         <= wr_stb && hit_ctrl && i_lb_wdata[0];
      end
   end

   // Read activity for the LED stretcher
   assign o_rd_pulse = rd_q1;

   // ------------------------------
   // Data select
   // ------------------------------
   always_comb begin
      status_word = '0;
      status_word[LB_STAT_RUN_BIT]  = (i_state == ST_RUN);
      status_word[LB_STAT_FULL_BIT] = (i_state == ST_FULL);
      status_word[LB_STAT_COUNT_LSB +: TRACE_AW+1] = i_rec_count;
   end

   // Record zero-extended to the bus width
   assign mem_word = lb_data_t'(i_mem_data);

   // Stage two, value holds until the next read
   always_ff @(posedge lb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_lb_rdata <= '0;
      end else if (rd_q1) begin
         if (sel_status_q1) begin
            o_lb_rdata <= status_word;
         end else if (sel_mem_q1) begin
            o_lb_rdata <= mem_word;
         end else begin
            // Control and unmapped addresses
            o_lb_rdata <= '0;
         end
      end
   end

   // ------------------------------
   // Checks
   // ------------------------------
   // Bus never delivers back-to-back arm writes
   a_arm_single : assert property (
      @(posedge lb_clk) disable iff (!i_arst_n)
      o_arm |=> !o_arm
   );

   // Unmapped reads return zero at the bus latency
   a_unmapped_zero : assert property (
      @(posedge lb_clk) disable iff (!i_arst_n)
      rd_stb && !hit_status && !hit_mem |-> ##LB_READ_LAT (o_lb_rdata == '0)
   );

endmodule

`default_nettype wire

// File: hw/status_leds.sv
// Board status LEDs
// Full and running flags, stretched bus read activity, heartbeat
`timescale 1ns/1ns
`default_nettype none

module status_leds #(
   parameter int HB_BIT = 24
) (
   input  logic                    lb_clk,
   input  logic                    i_arst_n,
   input  trace_pkg::store_state_t i_state,
   input  logic                    i_rd_pulse,
   output logic [3:0]              o_led
);
   import trace_pkg::*;

   logic [HB_BIT:0] hb_cnt;
   logic [7:0]      rd_stretch;

   // Free-running heartbeat and read pulse stretcher
   always_ff @(posedge lb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         hb_cnt     <= '0;
         rd_stretch <= '0;
      end else begin
         hb_cnt <= hb_cnt + 1'b1;
         // Reload on every read, 255 cycles lit
         if (i_rd_pulse) begin
            rd_stretch <= '1;
         end else if (rd_stretch != '0) begin
            rd_stretch <= rd_stretch - 1'b1;
         end
      end
   end

   // LED[3] running, LED[2] heartbeat, LED[1] bus read, LED[0] full
   assign o_led = {(i_state == ST_RUN), hb_cnt[HB_BIT], (rd_stretch != '0), (i_state == ST_FULL)};

endmodule

`default_nettype wire

// File: hw/trace_lb_top.sv
// Trace scope local-bus subsystem
// Run encoder, record store and bus readout in a row,
// with the status LEDs alongside
`timescale 1ns/1ns
`default_nettype none

module trace_lb_top #(
   parameter int HB_BIT = 24
) (
   input  logic                   lb_clk,
   input  logic                   i_arst_n,
   input  logic                   i_lb_valid,
   input  logic                   i_lb_rnw,
   input  lb_pkg::lb_addr_t       i_lb_addr,
   input  lb_pkg::lb_data_t       i_lb_wdata,
   input  logic                   i_lb_renable,
   output lb_pkg::lb_data_t       o_lb_rdata,
   input  trace_pkg::trace_data_t i_trace_data,
   output logic [3:0]             o_led
);
   import trace_pkg::*;

   // ------------------------------
   // Stage links
   // ------------------------------
   logic         arm_stb;
   logic         rec_valid;
   trace_rec_t   rec_data;
   store_state_t store_state;
   trace_count_t rec_count;
   trace_rec_t   mem_rd_data;
   trace_addr_t  mem_rd_addr;
   logic         rd_pulse;

   // Sample stream to run records
   trace_run_encoder i_trace_run_encoder (
      .lb_clk      (lb_clk),
      .i_arst_n    (i_arst_n),
      .i_arm       (arm_stb),
      .i_sample    (i_trace_data),
      .o_rec_valid (rec_valid),
      .o_rec       (rec_data)
   );

   // Record memory and arming FSM
   trace_store i_trace_store (
      .lb_clk      (lb_clk),
      .i_arst_n    (i_arst_n),
      .i_arm       (arm_stb),
      .i_rec_valid (rec_valid),
      .i_rec       (rec_data),
      .i_rd_addr   (mem_rd_addr),
      .o_rd_data   (mem_rd_data),
      .o_state     (store_state),
      .o_rec_count (rec_count)
   );

   // Host access over the bridge bus
   lb_read_mux i_lb_read_mux (
      .lb_clk       (lb_clk),
      .i_arst_n     (i_arst_n),
      .i_lb_valid   (i_lb_valid),
      .i_lb_rnw     (i_lb_rnw),
      .i_lb_addr    (i_lb_addr),
      .i_lb_wdata   (i_lb_wdata),
      .i_lb_renable (i_lb_renable),
      .i_state      (store_state),
      .i_rec_count  (rec_count),
      .i_mem_data   (mem_rd_data),
      .o_mem_addr   (mem_rd_addr),
      .o_arm        (arm_stb),
      .o_rd_pulse   (rd_pulse),
      .o_lb_rdata   (o_lb_rdata)
   );

   status_leds #(
      .HB_BIT (HB_BIT)
   ) i_status_leds (
      .lb_clk     (lb_clk),
      .i_arst_n   (i_arst_n),
      .i_state    (store_state),
      .i_rd_pulse (rd_pulse),
      .o_led      (o_led)
   );

endmodule

`default_nettype wire

// File: sim/tb_trace_lb_top.sv
// Testbench for the trace scope local-bus subsystem
// Directed tests over the local bus: status, arming, short and long
// runs, memory full, re-arm, and the board LEDs
`timescale 1ns/1ns
`default_nettype none

module tb_trace_lb_top;
   import lb_pkg::*;
   import trace_pkg::*;

   logic        lb_clk;
   logic        i_arst_n;
   logic        i_lb_valid;
   logic        i_lb_rnw;
   lb_addr_t    i_lb_addr;
   lb_data_t    i_lb_wdata;
   logic        i_lb_renable;
   lb_data_t    o_lb_rdata;
   trace_data_t i_trace_data;
   logic [3:0]  o_led;

   int          errors = 0;
   int          checks = 0;
   int          cycle = 0;
   int unsigned seed_init;
   // Test 4 records, reused by the re-arm test
   trace_rec_t  first_recs [TRACE_DEPTH];

   trace_lb_top #(
      .HB_BIT (4)
   ) i_trace_lb_top (
      .lb_clk       (lb_clk),
      .i_arst_n     (i_arst_n),
      .i_lb_valid   (i_lb_valid),
      .i_lb_rnw     (i_lb_rnw),
      .i_lb_addr    (i_lb_addr),
      .i_lb_wdata   (i_lb_wdata),
      .i_lb_renable (i_lb_renable),
      .o_lb_rdata   (o_lb_rdata),
      .i_trace_data (i_trace_data),
      .o_led        (o_led)
   );

   // 40 ns clock
   initial begin
      lb_clk = 1'b0;
      forever #20 lb_clk = ~lb_clk;
   end

   // Cycle count for run lengths measured across bus traffic
   always @(posedge lb_clk) cycle <= cycle + 1;

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic check_data(input string name, input lb_data_t exp, input lb_data_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_rec(input string name, input trace_rec_t exp, input trace_rec_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_led(input string name, input logic [3:0] exp, input logic [3:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s expected %b actual %b", name, exp, act);
      end
   endtask

   // Status layout: bit 0 running, bit 1 full, count in 14:8
   function automatic lb_data_t expected_status(input logic run, input logic full,
                                                input int count);
      lb_data_t w;
      w = '0;
      w[0] = run;
      w[1] = full;
      w[14:8] = count[6:0];
      return w;
   endfunction

   // Random sample that differs from the previous one
   function automatic trace_data_t next_value(input trace_data_t prev);
      trace_data_t v;
      v = trace_data_t'($urandom);
      while (v == prev) begin
         v = trace_data_t'($urandom);
      end
      return v;
   endfunction

   // ------------------------------
   // Bus tasks
   // ------------------------------
   task automatic lb_write(input lb_addr_t addr, input lb_data_t data);
      @(posedge lb_clk);
      i_lb_valid <= 1'b1;
      i_lb_rnw   <= 1'b0;
      i_lb_addr  <= addr;
      i_lb_wdata <= data;
      @(posedge lb_clk);
      i_lb_valid <= 1'b0;
      i_lb_rnw   <= 1'b1;
   endtask

   // Data sampled mid-cycle, LB_READ_LAT cycles after the strobe
   task automatic lb_read(input lb_addr_t addr, output lb_data_t data);
      @(posedge lb_clk);
      i_lb_valid   <= 1'b1;
      i_lb_rnw     <= 1'b1;
      i_lb_addr    <= addr;
      i_lb_renable <= 1'b1;
      @(posedge lb_clk);
      i_lb_valid <= 1'b0;
      repeat (LB_READ_LAT - 1) @(posedge lb_clk);
      @(negedge lb_clk);
      data = o_lb_rdata;
      @(posedge lb_clk);
      i_lb_renable <= 1'b0;
   endtask

   task automatic arm_trace();
      lb_write(LB_ADDR_CTRL, 32'h1);
   endtask

   // Memory word: record in the low bits, zero above
   task automatic read_rec(input string name, input int idx, input trace_rec_t exp);
      lb_data_t d;
      lb_read(LB_ADDR_MEM_BASE + lb_addr_t'(idx), d);
      check_rec(name, exp, d[TRACE_RW-1:0]);
      check_data({name, "_upper"}, '0, d >> TRACE_RW);
   endtask

   // Poll status until the record count arrives
   task automatic wait_count(input int exp_cnt, input string name);
      lb_data_t d;
      int tries;
      tries = 0;
      lb_read(LB_ADDR_STATUS, d);
      while (d[14:8] !== exp_cnt[6:0] && tries < 20) begin
         lb_read(LB_ADDR_STATUS, d);
         tries++;
      end
      if (d[14:8] !== exp_cnt[6:0]) begin
         errors++;
         $display("%s: record count stuck at %0d, waited for %0d", name, d[14:8], exp_cnt);
      end
   endtask

   task automatic wait_led(input int idx, input logic val, input int limit, input string name);
      int n;
      n = 0;
      @(negedge lb_clk);
      while (o_led[idx] !== val && n < limit) begin
         @(negedge lb_clk);
         n++;
      end
      if (o_led[idx] !== val) begin
         errors++;
         $display("%s: LED %0d did not reach %b within %0d cycles", name, idx, val, limit);
      end
   endtask

   // ------------------------------
   // Tests
   // ------------------------------
   task automatic test_reset_state();
      lb_data_t d;
      @(negedge lb_clk);
      // Heartbeat free to run, others dark
      check_led("reset_leds", 4'b0000, o_led & 4'b1011);
      lb_read(LB_ADDR_STATUS, d);
      check_data("reset_status", 32'h0, d);
      lb_read(24'h000080, d);
      check_data("unmapped_read", 32'h0, d);
   endtask

   task automatic test_short_runs();
      trace_data_t vals [10];
      int lens [10];
      trace_data_t v;
      lb_data_t d;
      arm_trace();
      v = i_trace_data;
      // First run counts from the arm cycle
      for (int i = 0; i < 10; i++) begin
         v = next_value(v);
         vals[i] = v;
         lens[i] = 1 + ($urandom % 20);
         i_trace_data <= v;
         repeat (lens[i]) @(posedge lb_clk);
      end
      i_trace_data <= next_value(v);
      wait_count(10, "short_runs");
      lb_read(LB_ADDR_STATUS, d);
      check_data("short_runs_status", expected_status(1'b1, 1'b0, 10), d);
      // Unmapped, low bits alias a filled record slot
      lb_read(24'h000041, d);
      check_data("short_runs_unmapped", 32'h0, d);
      for (int i = 0; i < 10; i++) begin
         read_rec("short_runs_rec", i, {trace_run_t'(lens[i]), vals[i]});
      end
   endtask

   task automatic test_long_run();
      trace_data_t w;
      lb_data_t d;
      arm_trace();
      w = next_value(i_trace_data);
      i_trace_data <= w;
      // 600 cycles split as 255 + 255 + 90
      repeat (600) @(posedge lb_clk);
      i_trace_data <= next_value(w);
      wait_count(3, "long_run");
      lb_read(LB_ADDR_STATUS, d);
      check_data("long_run_status", expected_status(1'b1, 1'b0, 3), d);
      read_rec("long_run_rec0", 0, {8'd255, w});
      read_rec("long_run_rec1", 1, {8'd255, w});
      read_rec("long_run_rec2", 2, {8'd90, w});
   endtask

   task automatic test_fill();
      trace_data_t v;
      lb_data_t d;
      arm_trace();
      v = next_value(i_trace_data);
      // New value each cycle, single-sample runs
      for (int i = 0; i < 80; i++) begin
         if (i < TRACE_DEPTH) begin
            first_recs[i] = {trace_run_t'(1), v};
         end
         i_trace_data <= v;
         @(posedge lb_clk);
         v = next_value(v);
      end
      wait_led(0, 1'b1, 50, "fill_led_full");
      // Full lit, running dark
      check_led("fill_leds", 4'b0001, o_led & 4'b1001);
      lb_read(LB_ADDR_STATUS, d);
      check_data("fill_status", expected_status(1'b0, 1'b1, 64), d);
      for (int i = 0; i < TRACE_DEPTH; i++) begin
         read_rec("fill_rec", i, first_recs[i]);
      end
   endtask

   task automatic test_rearm();
      trace_data_t a;
      lb_data_t d;
      int start;
      int len;
      arm_trace();
      a = next_value(i_trace_data);
      i_trace_data <= a;
      start = cycle;
      lb_read(LB_ADDR_STATUS, d);
      check_data("rearm_status", expected_status(1'b1, 1'b0, 0), d);
      wait_led(3, 1'b1, 10, "rearm_led_run");
      // Running lit, full dark
      check_led("rearm_leds", 4'b1000, o_led & 4'b1001);
      // Close the first run, its length spans the bus traffic
      @(posedge lb_clk);
      i_trace_data <= next_value(a);
      len = cycle - start;
      wait_count(1, "rearm");
      read_rec("rearm_rec0", 0, {trace_run_t'(len), a});
      // Index 1 untouched since the fill
      read_rec("rearm_rec1", 1, first_recs[1]);
   endtask

   task automatic test_leds();
      lb_data_t d;
      logic prev;
      @(negedge lb_clk);
      prev = o_led[2];
      // HB_BIT of 4, so 16 cycles per toggle
      for (int k = 0; k < 4; k++) begin
         repeat (16) @(negedge lb_clk);
         check_led("heartbeat", {1'b0, ~prev, 2'b00}, o_led & 4'b0100);
         prev = o_led[2];
      end
      wait_led(1, 1'b0, 300, "read_led_off");
      lb_read(LB_ADDR_STATUS, d);
      wait_led(1, 1'b1, 4, "read_led_on");
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      seed_init    = $urandom(32'he574);
      i_arst_n     = 1'b0;
      i_lb_valid   = 1'b0;
      i_lb_rnw     = 1'b1;
      i_lb_addr    = '0;
      i_lb_wdata   = '0;
      i_lb_renable = 1'b0;
      i_trace_data = '0;
      repeat (2) @(posedge lb_clk);
      i_arst_n <= 1'b1;

      test_reset_state();
      test_short_runs();
      test_long_run();
      test_fill();
      test_rearm();
      test_leds();

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
hw/lb_pkg.sv
hw/trace_pkg.sv
hw/trace_run_encoder.sv
hw/trace_store.sv
hw/lb_read_mux.sv
hw/status_leds.sv
hw/trace_lb_top.sv
sim/tb_trace_lb_top.sv
